// ==== sim/tb_tf_8to512.sv ====
`include "tf_consts.svh"

module tb_tf_8to512;

	logic                  clk = 1'b0;
	logic                  rst_n;
	logic [7:0]            rx_tdata;
	logic                  rx_tvalid;
	logic                  rx_tlast;
	logic                  out_alf;
	logic [`TF_WORD_W-1:0] out_word;
	logic                  out_wr;
	logic [`TF_META_W-1:0] out_meta;
	logic                  out_meta_wr;

	logic [`TF_WORD_W-1:0] exp_words [$];
	logic [`TF_META_W-1:0] exp_meta [$];
	logic [7:0]            hdr_log [$];   // headers seen, for directed checks
	logic [`TF_META_W-1:0] last_meta;
	logic [7:0]            pkt_buf [0:2047];
	integer                seed;
	int                    cyc = 0;
	int                    last_in_cycle = -1;
	int                    last_wr_cycle = -1;

	tf_8to512 u_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.rx_tdata    (rx_tdata),
		.rx_tvalid   (rx_tvalid),
		.rx_tlast    (rx_tlast),
		.out_alf     (out_alf),
		.out_word    (out_word),
		.out_wr      (out_wr),
		.out_meta    (out_meta),
		.out_meta_wr (out_meta_wr)
	);

	always #10 clk = ~clk;

	always @(posedge clk) cyc <= cyc + 1;

	// ============================================================
	// helpers
	// ============================================================
	task automatic stop_run;
		$display("TEST FAILED");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic check_equal(input logic [`TF_WORD_W-1:0] got,
			input logic [`TF_WORD_W-1:0] exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
			stop_run();
		end
	endtask

	// expected words and metadata for pkt_buf[0..len-1]
	function automatic void ref_words(input int len);
		logic [`TF_WORD_W-1:0] w;
		logic [`TF_META_W-1:0] m;
		logic [1:0]            tag;
		int                    pos;
		int                    fill;
		int                    k;
		pos = 0;
		while (pos < len) begin
			fill = (len - pos > 64) ? 64 : len - pos;
			w = '0;
			for (k = 0; k < fill; k++)
				w[511 - 8*k -: 8] = pkt_buf[pos + k]; // first byte in top lane
			if (pos == 0 && pos + fill == len)
				tag = `TF_TAG_ONLY;
			else if (pos == 0)
				tag = `TF_TAG_FIRST;
			else if (pos + fill == len)
				tag = `TF_TAG_LAST;
			else
				tag = `TF_TAG_MID;
			w[519:518] = tag;
			w[517:512] = 6'((64 - fill) % 64);
			exp_words.push_back(w);
			pos = pos + fill;
		end
		m = '0;
		m[111]    = 1'b1;
		m[106:96] = len[10:0];
		m[31:0]   = `TF_META_TAIL;
		exp_meta.push_back(m);
	endfunction

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			rx_tvalid <= 1'b0;
			rx_tlast  <= 1'b0;
			rx_tdata  <= 8'h00;
			out_alf   <= 1'b0;
		end
	endtask

	// alf_mode 0 low, 1 high on first byte only, 2 high after first byte
	task automatic send_packet(input int len, input int alf_mode);
		int i;
		for (i = 0; i < len; i++) begin
			@(posedge clk);
			rx_tvalid <= 1'b1;
			rx_tdata  <= pkt_buf[i];
			rx_tlast  <= (i == len - 1);
			if (alf_mode == 1)
				out_alf <= (i == 0);
			else if (alf_mode == 2)
				out_alf <= (i != 0);
			else
				out_alf <= 1'b0;
		end
	endtask

	task automatic fill_pattern(input int len);
		int i;
		for (i = 0; i < len; i++)
			pkt_buf[i] = 8'(i * 7 + 3);
	endtask

	task automatic wait_drain;
		int t;
		t = 0;
		while ((exp_words.size() != 0 || exp_meta.size() != 0) && t < 2000) begin
			@(negedge clk);
			t++;
		end
		if (exp_words.size() != 0 || exp_meta.size() != 0) begin
			$display("timeout: the DUT never delivered all expected words");
			stop_run();
		end
		idle_cycles(4); // catch any stray trailing word
	endtask

	// ============================================================
	// comparison
	// ============================================================
	always @(negedge clk) begin
		if (rst_n) begin
			if (rx_tvalid && rx_tlast)
				last_in_cycle = cyc;
			if (out_wr) begin
				if (exp_words.size() == 0) begin
					$display("unexpected output word at time %0t, none was expected", $time);
					stop_run();
				end
				check_equal(out_word, exp_words.pop_front(), "output word");
				hdr_log.push_back(out_word[519:512]);
				last_wr_cycle = cyc;
			end
			if (out_meta_wr) begin
				if (exp_meta.size() == 0) begin
					$display("unexpected metadata word at time %0t, none was expected", $time);
					stop_run();
				end
				check_equal(out_meta, exp_meta.pop_front(), "metadata");
				last_meta = out_meta;
			end
		end
	end

	// ============================================================
	// stimulus
	// ============================================================
	initial begin
		int n;
		int len;
		int mode;
		int mark;
		int t;
		seed      = 57;
		rst_n     = 1'b0;
		rx_tdata  = 8'h00;
		rx_tvalid = 1'b0;
		rx_tlast  = 1'b0;
		out_alf   = 1'b0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;

		// quiet after reset
		for (n = 0; n < 10; n++) begin
			@(negedge clk);
			check_equal(out_wr, 1'b0, "out_wr idle");
			check_equal(out_meta_wr, 1'b0, "out_meta_wr idle");
			check_equal(out_word, '0, "out_word idle");
			check_equal(out_meta, '0, "out_meta idle");
		end

		// short single word
		hdr_log.delete();
		fill_pattern(5);
		ref_words(5);
		send_packet(5, 0);
		idle_cycles(1);
		wait_drain();
		check_equal(hdr_log.size(), 1, "5-byte word count");
		check_equal(hdr_log[0], {`TF_TAG_ONLY, 6'd59}, "5-byte header");
		check_equal(last_meta[106:96], 5, "5-byte length");

		// exactly one full word, then three words
		hdr_log.delete();
		fill_pattern(64);
		ref_words(64);
		send_packet(64, 0);
		idle_cycles(1);
		wait_drain();
		check_equal(hdr_log[0], {`TF_TAG_ONLY, 6'd0}, "64-byte header");
		check_equal(last_meta[106:96], 64, "64-byte length");
		hdr_log.delete();
		fill_pattern(150);
		ref_words(150);
		send_packet(150, 0);
		idle_cycles(1);
		wait_drain();
		check_equal(hdr_log.size(), 3, "150-byte word count");
		check_equal(hdr_log[0], {`TF_TAG_FIRST, 6'd0}, "150-byte first header");
		check_equal(hdr_log[1], {`TF_TAG_MID, 6'd0}, "150-byte middle header");
		check_equal(hdr_log[2], {`TF_TAG_LAST, 6'd42}, "150-byte last header");
		check_equal(last_meta[106:96], 150, "150-byte length");

		// almost-full at start drops the whole packet
		hdr_log.delete();
		fill_pattern(20);
		send_packet(20, 1);
		idle_cycles(1);
		wait_drain();
		fill_pattern(30);
		ref_words(30);
		send_packet(30, 0);
		fill_pattern(70);
		ref_words(70);
		send_packet(70, 2); // alf rises mid packet
		idle_cycles(1);
		wait_drain();
		check_equal(hdr_log.size(), 3, "words after drop");

		// random packets, gaps and back-to-back starts
		for (n = 0; n < 40; n++) begin
			len  = 1 + ({$random(seed)} % 300);
			mode = {$random(seed)} % 8;
			mode = (mode == 0) ? 1 : (mode < 4 ? 2 : 0);
			for (t = 0; t < len; t++)
				pkt_buf[t] = $random(seed);
			if (mode != 1)
				ref_words(len);
			send_packet(len, mode);
			t = {$random(seed)} % 4;
			if (t > 0)
				idle_cycles(t);
		end
		idle_cycles(1);
		wait_drain();

		// latency from last byte to word strobe
		mark = last_wr_cycle;
		fill_pattern(10);
		ref_words(10);
		send_packet(10, 0);
		idle_cycles(1);
		t = 0;
		while (last_wr_cycle == mark && t < 100) begin
			@(negedge clk);
			t++;
		end
		if (last_wr_cycle == mark) begin
			$display("timeout: no output word appeared for the latency packet");
			stop_run();
		end
		check_equal(last_wr_cycle - last_in_cycle, 2, "last byte to out_wr latency");
		wait_drain();

		if (exp_words.size() == 0 && exp_meta.size() == 0) begin
			$display("TEST PASSED");
			$finish;
		end else begin
			$display("expected words were left unmatched at the end of the run");
			stop_run();
		end
	end

endmodule

// ==== source/byte_packer.sv ====
`include "tf_consts.svh"

module byte_packer (
	input  logic       clk,
	input  logic       rst_n,
	input  logic [7:0] rx_tdata,
	input  logic       take,
	input  logic       take_last,
	lane_if.packer     lw
);

	tf_pkg::lane_word_u acc;     // word under assembly
	tf_pkg::lane_word_u acc_nxt;
	logic [5:0]         lane;    // next lane to fill
	logic               done;

	// word closes on lane 63 or on the packet's last byte
	assign done = take && (take_last || lane == 6'(`TF_LANES - 1));

	always_comb begin
		acc_nxt = acc;
		acc_nxt.lanes[lane] = rx_tdata;
	end

	// ============================================================
	// lane assembly
	// ============================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc  <= '0;
			lane <= '0;
		end else if (done) begin
			acc  <= '0;   // unwritten lanes stay zero
			lane <= '0;
		end else if (take) begin
			acc  <= acc_nxt;
			lane <= lane + 6'd1;
		end
	end

	// ============================================================
	// finished word
	// ============================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lw.word_vld <= 1'b0;
		end else begin
			lw.word_vld <= done;
		end
	end

	always_ff @(posedge clk) begin
		if (done) begin
			lw.word      <= acc_nxt;
			lw.fill      <= {1'b0, lane} + `TF_FILL_W'(1);
			lw.word_last <= take_last;
		end
	end

endmodule

// ==== source/lane_if.sv ====
`include "tf_consts.svh"

// finished words, packer to formatter
interface lane_if;

	tf_pkg::lane_word_u      word;
	logic                    word_vld;  // one cycle per word
	logic [`TF_FILL_W-1:0]   fill;      // valid lanes, 1 to 64
	logic                    word_last; // closes the packet

	modport packer (
		output word,
		output word_vld,
		output fill,
		output word_last
	);

	modport formatter (
		input word,
		input word_vld,
		input fill,
		input word_last
	);

endinterface

// ==== source/pkt_tracker.sv ====
`include "tf_consts.svh"

module pkt_tracker (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 rx_tvalid,
	input  logic                 rx_tlast,
	input  logic                 out_alf,
	output logic                 take,
	output logic                 take_last,
	output logic [`TF_LEN_W-1:0] pkt_len
);

	localparam logic [1:0] ST_IDLE   = 2'd0;
	localparam logic [1:0] ST_ACTIVE = 2'd1;
	localparam logic [1:0] ST_DROP   = 2'd2; // discarding until last byte

	logic [1:0] state;
	logic [1:0] state_nxt;

	// almost-full only matters on the first byte
	assign take      = rx_tvalid && ((state == ST_IDLE && !out_alf) || state == ST_ACTIVE);
	assign take_last = take && rx_tlast;

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: begin
				if (rx_tvalid && !rx_tlast)
					state_nxt = out_alf ? ST_DROP : ST_ACTIVE;
			end
			ST_ACTIVE,
			ST_DROP: begin
				if (rx_tvalid && rx_tlast)
					state_nxt = ST_IDLE;
			end
			default: state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// accepted bytes so far, restarts on a new packet
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pkt_len <= '0;
		end else if (take) begin
			if (state == ST_IDLE)
				pkt_len <= `TF_LEN_W'(1);
			else
				pkt_len <= pkt_len + `TF_LEN_W'(1);
		end
	end

endmodule

// ==== source/tf_8to512.sv ====
`include "tf_consts.svh"

module tf_8to512 (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [7:0]            rx_tdata,
	input  logic                  rx_tvalid,
	input  logic                  rx_tlast,
	input  logic                  out_alf,
	output logic [`TF_WORD_W-1:0] out_word,
	output logic                  out_wr,
	output logic [`TF_META_W-1:0] out_meta,
	output logic                  out_meta_wr
);

	logic                 take;
	logic                 take_last;
	logic [`TF_LEN_W-1:0] pkt_len;

	lane_if lw ();

	// admission and length
	pkt_tracker u_tracker (
		.clk       (clk),
		.rst_n     (rst_n),
		.rx_tvalid (rx_tvalid),
		.rx_tlast  (rx_tlast),
		.out_alf   (out_alf),
		.take      (take),
		.take_last (take_last),
		.pkt_len   (pkt_len)
	);

	byte_packer u_packer (
		.clk       (clk),
		.rst_n     (rst_n),
		.rx_tdata  (rx_tdata),
		.take      (take),
		.take_last (take_last),
		.lw        (lw.packer)
	);

	// header, metadata, output registers
	word_formatter u_formatter (
		.clk         (clk),
		.rst_n       (rst_n),
		.lw          (lw.formatter),
		.pkt_len     (pkt_len),
		.out_word    (out_word),
		.out_wr      (out_wr),
		.out_meta    (out_meta),
		.out_meta_wr (out_meta_wr)
	);

endmodule

// ==== source/tf_consts.svh ====
`ifndef TF_CONSTS_SVH
`define TF_CONSTS_SVH

// ============================================================
// word geometry
// ============================================================
`define TF_LANES      64    // byte lanes per data word
`define TF_DATA_W     512
`define TF_WORD_W     520   // data plus tag and empty count
`define TF_LEN_W      11    // packet length in bytes
`define TF_FILL_W     7     // lane fill count, 1 to 64

// ============================================================
// position tags, top two bits of the output word
// ============================================================
`define TF_TAG_FIRST  2'b10 // first of several
`define TF_TAG_MID    2'b00
`define TF_TAG_LAST   2'b01 // last of several
`define TF_TAG_ONLY   2'b11 // single word packet

// ============================================================
// metadata word
// bit 111 valid, 106..96 length, 31..0 tail constant
// ============================================================
`define TF_META_W     112
`define TF_META_TAIL  32'd1

`endif

// ==== source/tf_pkg.sv ====
`include "tf_consts.svh"

package tf_pkg;

	// one data word, written per byte lane and read as a flat vector
	// lane 0 sits in bits 511..504
	typedef union packed {
		logic [0:`TF_LANES-1][7:0] lanes;
		logic [`TF_DATA_W-1:0]     flat;
	} lane_word_u;

endpackage

// ==== source/word_formatter.sv ====
`include "tf_consts.svh"

module word_formatter (
	input  logic                  clk,
	input  logic                  rst_n,
	lane_if.formatter             lw,
	input  logic [`TF_LEN_W-1:0]  pkt_len,
	output logic [`TF_WORD_W-1:0] out_word,
	output logic                  out_wr,
	output logic [`TF_META_W-1:0] out_meta,
	output logic                  out_meta_wr
);

	logic                  first;
	logic [1:0]            tag;
	logic [5:0]            empty;
	logic [`TF_META_W-1:0] meta;

	// first word holds every byte counted so far
	assign first = pkt_len == {{(`TF_LEN_W - `TF_FILL_W){1'b0}}, lw.fill};

	always_comb begin
		case ({first, lw.word_last})
			2'b11:   tag = `TF_TAG_ONLY;
			2'b10:   tag = `TF_TAG_FIRST;
			2'b01:   tag = `TF_TAG_LAST;
			default: tag = `TF_TAG_MID;
		endcase
	end

	assign empty = 6'(`TF_LANES - lw.fill); // full word wraps to 0

	// valid, reserved, length, reserved, tail
	assign meta = {1'b1, 4'b0, pkt_len, 64'b0, `TF_META_TAIL};

	// ============================================================
	// output registers
	// ============================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_wr      <= 1'b0;
			out_meta_wr <= 1'b0;
		end else begin
			out_wr      <= lw.word_vld;
			out_meta_wr <= lw.word_vld && lw.word_last;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_word <= '0;
			out_meta <= '0;
		end else if (lw.word_vld) begin
			out_word <= {tag, empty, lw.word.flat};
			if (lw.word_last)
				out_meta <= meta; // one per packet
		end
	end

endmodule

// ==== src.f ====
+incdir+source
source/tf_pkg.sv
source/lane_if.sv
source/pkt_tracker.sv
source/byte_packer.sv
source/word_formatter.sv
source/tf_8to512.sv
sim/tb_tf_8to512.sv
